//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_user_io -f vlog.f -o sim_tb_user_io

./obj_dir/sim_tb_user_io > sim.log 2>&1
cat sim.log

grep -q "^All tests passed$" sim.log

//--- source/cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder (
	input  logic                                clk_sys,
	input  user_io_pkg::spi_rx_t                link,
	output logic [user_io_pkg::JOY_W-1:0]       joystick_0,
	output logic [user_io_pkg::JOY_W-1:0]       joystick_1,
	output logic [user_io_pkg::STATUS_W-1:0]    status,
	output user_io_pkg::but_sw_t                but_sw,
	output user_io_pkg::key_event_t             key,
	output logic                                key_strobe,
	output logic [user_io_pkg::BYTE_W-1:0]      key_byte,
	output logic                                key_valid,
	input  logic                                key_ready
);
	import user_io_pkg::*;

	// two flop synchronizer plus delayed toggle
	spi_rx_t link_meta = '{byte_toggle: 1'b0, transfer_end: 1'b1, rx_byte: '0};
	spi_rx_t link_sync = '{byte_toggle: 1'b0, transfer_end: 1'b1, rx_byte: '0};
	logic    toggle_d  = 1'b0;
	logic    new_byte;

	logic [BYTE_CNT_W-1:0] byte_cnt = '0;
	logic [1:0]            lane;
	logic                  first_data;
	cmd_e                  cmd;

	// output registers with power-up values
	logic [JOY_W-1:0]    joy0_q   = '0;
	logic [JOY_W-1:0]    joy1_q   = '0;
	logic [STATUS_W-1:0] status_q = '0;
	but_sw_t             but_sw_q = '0;
	key_event_t          key_q    = '0;
	logic                strobe_q = 1'b0;
	logic                valid_q  = 1'b0;
	logic [BYTE_W-1:0]   kbyte_q;

	// key flags collected from prefix bytes
	logic pressed_r  = 1'b1;
	logic extended_r = 1'b0;

	always_ff @(posedge clk_sys) begin
		link_meta <= link;
		link_sync <= link_meta;
		toggle_d <= link_sync.byte_toggle;
	end

	assign new_byte = link_sync.byte_toggle ^ toggle_d;

	// data byte n lands in lane n-1
	assign lane = 2'(byte_cnt - 1'b1);
	assign first_data = (byte_cnt == BYTE_CNT_W'(1));

	always_ff @(posedge clk_sys) begin
		key_strobe_clear: begin
			strobe_q <= 1'b0;
			valid_q <= 1'b0;
		end
		if (link_sync.transfer_end) begin
			byte_cnt <= '0;
		end else if (new_byte) begin
			if (~&byte_cnt)
				byte_cnt <= byte_cnt + 1'b1;

			if (byte_cnt == '0) begin
				// command byte
				cmd <= cmd_e'(link_sync.rx_byte);
			end else begin
				case (cmd)
					CMD_BUT_SW: begin
						if (first_data)
							but_sw_q <= but_sw_t'(link_sync.rx_byte);
					end
					CMD_JOY0: begin
						if (byte_cnt <= BYTE_CNT_W'(4))
							joy0_q[lane*BYTE_W +: BYTE_W] <= link_sync.rx_byte;
					end
					CMD_JOY1: begin
						if (byte_cnt <= BYTE_CNT_W'(4))
							joy1_q[lane*BYTE_W +: BYTE_W] <= link_sync.rx_byte;
					end
					CMD_STATUS: begin
						if (byte_cnt <= BYTE_CNT_W'(4))
							status_q[lane*BYTE_W +: BYTE_W] <= link_sync.rx_byte;
					end
					CMD_KBD: begin
						// raw byte goes to the ps2 fifo
						kbyte_q <= link_sync.rx_byte;
						valid_q <= 1'b1;
						// fresh flags at the first data byte
						if (first_data) begin
							pressed_r <= 1'b1;
							extended_r <= 1'b0;
						end
						if (link_sync.rx_byte == KEY_EXT_PREFIX) begin
							extended_r <= 1'b1;
						end else if (link_sync.rx_byte == KEY_BREAK_PREFIX) begin
							pressed_r <= 1'b0;
						end else begin
							key_q <= '{
								pressed:  pressed_r | first_data,
								extended: extended_r & ~first_data,
								code:     link_sync.rx_byte
							};
							strobe_q <= 1'b1;
						end
					end
					default: begin
					end
				endcase
			end
		end
	end

	assign joystick_0 = joy0_q;
	assign joystick_1 = joy1_q;
	assign status = status_q;
	assign but_sw = but_sw_q;
	assign key = key_q;
	assign key_strobe = strobe_q;
	assign key_byte = kbyte_q;
	// fifo full drops the byte, the spi side cannot stall
	assign key_valid = valid_q;

	// bytes arrive far apart, so an event never repeats next cycle
	a_strobe_single: assert property (
		@(posedge clk_sys) key_strobe |=> !key_strobe
	);

endmodule

//--- source/ps2_fifo.sv
`timescale 1ns/1ps

module ps2_fifo #(
	parameter int FIFO_BITS = 3
) (
	input  logic                           clk_sys,
	input  logic [user_io_pkg::BYTE_W-1:0] key_byte,
	input  logic                           key_valid,
	output logic                           key_ready,
	output logic [user_io_pkg::BYTE_W-1:0] tx_byte,
	output logic                           tx_valid,
	input  logic                           tx_ready
);
	import user_io_pkg::*;

	localparam int DEPTH = 1 << FIFO_BITS;

	logic [BYTE_W-1:0] mem [DEPTH];
	// pointers carry one extra wrap bit
	logic [FIFO_BITS:0] wr_ptr = '0;
	logic [FIFO_BITS:0] rd_ptr = '0;
	logic               full;
	logic               empty;
	logic               push;
	logic               pop;

	assign empty = (wr_ptr == rd_ptr);
	// same slot, different lap
	assign full = (wr_ptr[FIFO_BITS] != rd_ptr[FIFO_BITS]) &&
		(wr_ptr[FIFO_BITS-1:0] == rd_ptr[FIFO_BITS-1:0]);

	assign key_ready = ~full;
	assign tx_valid = ~empty;
	assign push = key_valid & key_ready;
	assign pop = tx_valid & tx_ready;

	always_ff @(posedge clk_sys) begin
		if (push) begin
			mem[wr_ptr[FIFO_BITS-1:0]] <= key_byte;
			wr_ptr <= wr_ptr + 1'b1;
		end
		if (pop)
			rd_ptr <= rd_ptr + 1'b1;
	end

	// head of queue
	assign tx_byte = mem[rd_ptr[FIFO_BITS-1:0]];

	// read pointer moves only over a stored byte
	a_no_pop_empty: assert property (
		@(posedge clk_sys) (rd_ptr != $past(rd_ptr)) |-> ($past(wr_ptr) != $past(rd_ptr))
	);

endmodule

//--- source/ps2_tx.sv
`timescale 1ns/1ps

module ps2_tx #(
	parameter int PS2_DIV = 100
) (
	input  logic                           clk_sys,
	input  logic [user_io_pkg::BYTE_W-1:0] tx_byte,
	input  logic                           tx_valid,
	output logic                           tx_ready,
	output logic                           ps2_kbd_clk,
	output logic                           ps2_kbd_data
);
	import user_io_pkg::*;

	localparam int CNT_W = $clog2(PS2_DIV + 1);

	logic [CNT_W-1:0]  div_cnt   = '0;
	logic              ps2_clk   = 1'b0;
	logic              ps2_clk_d = 1'b0;
	logic              tick;
	ps2_state_e        state     = IDLE;
	logic [2:0]        bit_idx;
	logic [BYTE_W-1:0] shift;
	logic              parity;
	logic              data_q    = 1'b1;

	// internal ps2 clock, half period of PS2_DIV+1 cycles
	always_ff @(posedge clk_sys) begin
		if (div_cnt == CNT_W'(PS2_DIV)) begin
			div_cnt <= '0;
			ps2_clk <= ~ps2_clk;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
		ps2_clk_d <= ps2_clk;
	end

	assign tick = ps2_clk & ~ps2_clk_d;
	// take a byte only at a tick while idle
	assign tx_ready = tick && (state == IDLE);

	// frame shifter, one bit per rising tick
	always_ff @(posedge clk_sys) begin
		if (tick) begin
			case (state)
				IDLE: begin
					if (tx_valid) begin
						shift <= tx_byte;
						// odd parity starts from one
						parity <= 1'b1;
						bit_idx <= '0;
						// start bit
						data_q <= 1'b0;
						state <= DATA;
					end
				end
				DATA: begin
					// lsb first
					data_q <= shift[0];
					shift <= shift >> 1;
					parity <= parity ^ shift[0];
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7)
						state <= PARITY;
				end
				PARITY: begin
					data_q <= parity;
					bit_idx <= '0;
					state <= STOP;
				end
				STOP: begin
					// stop bit, then one idle tick
					if (bit_idx == '0) begin
						data_q <= 1'b1;
						bit_idx <= 3'd1;
					end else begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// clock held high while nothing is sent
	assign ps2_kbd_clk = ps2_clk | (state == IDLE);
	assign ps2_kbd_data = data_q;

	// a frame starts only with a handshake from the fifo
	a_start_on_transfer: assert property (
		@(posedge clk_sys) (state != IDLE && $past(state) == IDLE) |->
			$past(tx_valid && tx_ready)
	);

endmodule

//--- source/spi_frame_rx.sv
`timescale 1ns/1ps

module spi_frame_rx #(
	parameter logic [user_io_pkg::BYTE_W-1:0] CORE_TYPE = 8'hA4
) (
	input  logic                 SPI_CLK,
	input  logic                 SPI_SS_IO,
	input  logic                 SPI_MOSI,
	output logic                 SPI_MISO,
	output user_io_pkg::spi_rx_t link
);
	import user_io_pkg::*;

	logic [2:0]            bit_cnt;
	logic [BYTE_CNT_W-1:0] byte_cnt;
	logic [BYTE_CNT_W-1:0] next_cnt;
	logic [BYTE_W-1:0]     reply;
	logic [BYTE_W-2:0]     sbuf;
	logic [BYTE_W-1:0]     rx_byte;
	logic                  byte_toggle = 1'b0;

	// reply byte per byte index
	// only the command byte carries the core identity
	function automatic logic [BYTE_W-1:0] reply_for(input logic [BYTE_CNT_W-1:0] idx);
		return (idx == '0) ? CORE_TYPE : '0;
	endfunction

	// saturating byte index for the next byte
	assign next_cnt = (&byte_cnt) ? byte_cnt : byte_cnt + 1'b1;

	// bit/byte counters and reply register
	// ss high holds the frame in its start state
	always_ff @(posedge SPI_CLK or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bit_cnt <= '0;
			byte_cnt <= '0;
			reply <= reply_for('0);
		end else begin
			bit_cnt <= bit_cnt + 1'b1;
			if (bit_cnt == 3'd7) begin
				byte_cnt <= next_cnt;
				// load reply for the byte that starts now
				reply <= reply_for(next_cnt);
			end
		end
	end

	// receive shifter, msb first
	// the 8th bit goes straight into the published byte
	always_ff @(posedge SPI_CLK) begin
		if (bit_cnt != 3'd7) begin
			sbuf <= {sbuf[BYTE_W-3:0], SPI_MOSI};
		end else begin
			rx_byte <= {sbuf, SPI_MOSI};
			// flip toggle to announce a new byte to clk_sys
			byte_toggle <= ~byte_toggle;
		end
	end

	// current reply bit, low while deselected
	assign SPI_MISO = ~SPI_SS_IO & reply[~bit_cnt];

	assign link = '{
		byte_toggle:  byte_toggle,
		transfer_end: SPI_SS_IO,
		rx_byte:      rx_byte
	};

	// a byte is published only at the end of its 8th bit
	a_toggle_on_last_bit: assert property (
		@(posedge SPI_CLK) disable iff (SPI_SS_IO)
		(byte_toggle != $past(byte_toggle)) |-> ($past(bit_cnt) == 3'd7)
	);

endmodule

//--- source/user_io.sv
`timescale 1ns/1ps

module user_io #(
	parameter logic [user_io_pkg::BYTE_W-1:0] CORE_TYPE = 8'hA4,
	parameter int PS2_DIV   = 100,
	parameter int FIFO_BITS = 3
) (
	input  logic                             clk_sys,
	input  logic                             SPI_CLK,
	input  logic                             SPI_SS_IO,
	input  logic                             SPI_MOSI,
	output logic                             SPI_MISO,
	output logic [user_io_pkg::JOY_W-1:0]    joystick_0,
	output logic [user_io_pkg::JOY_W-1:0]    joystick_1,
	output logic [user_io_pkg::STATUS_W-1:0] status,
	output logic [1:0]                       buttons,
	output logic [1:0]                       switches,
	output logic                             scandoubler_disable,
	output logic                             ypbpr,
	output logic                             no_csync,
	output user_io_pkg::key_event_t          key,
	output logic                             key_strobe,
	output logic                             ps2_kbd_clk,
	output logic                             ps2_kbd_data
);
	import user_io_pkg::*;

	spi_rx_t           link;
	but_sw_t           but_sw;
	logic [BYTE_W-1:0] key_byte;
	logic              key_valid;
	logic              key_ready;
	logic [BYTE_W-1:0] tx_byte;
	logic              tx_valid;
	logic              tx_ready;

	// spi side, bytes and identity reply
	spi_frame_rx #(.CORE_TYPE(CORE_TYPE)) u_spi_frame_rx (
		.SPI_CLK, .SPI_SS_IO, .SPI_MOSI, .SPI_MISO, .link
	);

	// clk_sys side command handling
	cmd_decoder u_cmd_decoder (
		.clk_sys, .link, .joystick_0, .joystick_1, .status, .but_sw,
		.key, .key_strobe, .key_byte, .key_valid, .key_ready
	);

	ps2_fifo #(.FIFO_BITS(FIFO_BITS)) u_ps2_fifo (
		.clk_sys, .key_byte, .key_valid, .key_ready, .tx_byte, .tx_valid, .tx_ready
	);

	ps2_tx #(.PS2_DIV(PS2_DIV)) u_ps2_tx (
		.clk_sys, .tx_byte, .tx_valid, .tx_ready, .ps2_kbd_clk, .ps2_kbd_data
	);

	// buttons byte fields
	assign buttons = but_sw.buttons;
	assign switches = but_sw.switches;
	assign scandoubler_disable = but_sw.scandoubler_disable;
	assign ypbpr = but_sw.ypbpr;
	assign no_csync = but_sw.no_csync;

endmodule

//--- source/user_io_pkg.sv
package user_io_pkg;

	// basic widths
	localparam int BYTE_W     = 8;
	localparam int JOY_W      = 32;
	localparam int STATUS_W   = 32;
	localparam int BYTE_CNT_W = 8;

	// keyboard prefix bytes
	localparam logic [BYTE_W-1:0] KEY_EXT_PREFIX   = 8'hE0;
	localparam logic [BYTE_W-1:0] KEY_BREAK_PREFIX = 8'hF0;

	// command byte sent first in every transfer
	typedef enum logic [BYTE_W-1:0] {
		CMD_BUT_SW = 8'h01,
		CMD_KBD    = 8'h05,
		CMD_STATUS = 8'h1E,
		CMD_JOY0   = 8'h60,
		CMD_JOY1   = 8'h61
	} cmd_e;

	// ps2 transmitter phases
	typedef enum logic [1:0] {
		IDLE,
		DATA,
		PARITY,
		STOP
	} ps2_state_e;

	// spi clock domain to clk_sys crossing
	typedef struct packed {
		logic              byte_toggle;
		logic              transfer_end;
		logic [BYTE_W-1:0] rx_byte;
	} spi_rx_t;

	typedef struct packed {
		logic              pressed;
		logic              extended;
		logic [BYTE_W-1:0] code;
	} key_event_t;

	// buttons/switches byte, msb first
	typedef struct packed {
		logic       spare;
		logic       no_csync;
		logic       ypbpr;
		logic       scandoubler_disable;
		logic [1:0] switches;
		logic [1:0] buttons;
	} but_sw_t;

endpackage

//--- test/tb_ps2_monitor.sv
`timescale 1ns/1ps

module tb_ps2_monitor (
	input  logic        clk_sys,
	input  logic        ps2_kbd_clk,
	input  logic        ps2_kbd_data,
	output logic [10:0] frame_word,
	output int          frame_cnt,
	output int          frame_errs
);
	// bits collected since the last complete frame
	logic [10:0] bits_q = '0;
	logic [10:0] word_q = '0;
	int          bit_n  = 0;
	int          cnt_q  = 0;
	int          errs_q = 0;
	logic        clk_q  = 1'b1;

	// lines change just after a rising clk_sys edge, so look at them on the falling one
	always @(negedge clk_sys) begin
		// keyboard data is valid at each falling ps2 clock
		if (clk_q && !ps2_kbd_clk) begin
			bits_q[bit_n] = ps2_kbd_data;
			if (bit_n == 10) begin
				// start, 8 data lsb first, parity, stop
				if (bits_q[0] !== 1'b0) begin
					$display("ps2 frame %0d has a start bit that is not low", cnt_q);
					errs_q++;
				end
				// data plus parity must hold an odd number of ones
				if ((^bits_q[9:1]) !== 1'b1) begin
					$display("ps2 frame %0d has a wrong parity bit", cnt_q);
					errs_q++;
				end
				if (bits_q[10] !== 1'b1) begin
					$display("ps2 frame %0d has a stop bit that is not high", cnt_q);
					errs_q++;
				end
				word_q = bits_q;
				cnt_q++;
				bit_n = 0;
			end else begin
				bit_n++;
			end
		end
		clk_q = ps2_kbd_clk;
	end

	assign frame_word = word_q;
	assign frame_cnt = cnt_q;
	assign frame_errs = errs_q;

endmodule

//--- test/tb_user_io.sv
`timescale 1ns/1ps

module tb_user_io;
	import user_io_pkg::*;

	localparam logic [7:0] CORE_ID = 8'hA4;
	localparam int PS2_DIV = 3;
	// about 50 spi bytes of 64 cycles plus 8 ps2 frames of ~104 cycles, times five
	localparam int TIMEOUT_CYCLES = 20000;

	logic                clk_sys;
	logic                SPI_CLK;
	logic                SPI_SS_IO;
	logic                SPI_MOSI;
	logic                SPI_MISO;
	logic [JOY_W-1:0]    joystick_0;
	logic [JOY_W-1:0]    joystick_1;
	logic [STATUS_W-1:0] status;
	logic [1:0]          buttons;
	logic [1:0]          switches;
	logic                scandoubler_disable;
	logic                ypbpr;
	logic                no_csync;
	key_event_t          key;
	logic                key_strobe;
	logic                ps2_kbd_clk;
	logic                ps2_kbd_data;
	logic [10:0]         mon_frame;
	int                  mon_cnt;
	int                  mon_errs;

	logic [31:0] rng_state = 32'h2579;
	logic [7:0]  tx_q[$];
	key_event_t  ev_q[$];
	logic [7:0]  byte_q[$];
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          frames_seen = 0;
	int          kbd_total = 0;

	user_io #(.CORE_TYPE(CORE_ID), .PS2_DIV(PS2_DIV)) UUT (
		.clk_sys, .SPI_CLK, .SPI_SS_IO, .SPI_MOSI, .SPI_MISO, .joystick_0, .joystick_1,
		.status, .buttons, .switches, .scandoubler_disable, .ypbpr, .no_csync,
		.key, .key_strobe, .ps2_kbd_clk, .ps2_kbd_data
	);

	tb_ps2_monitor u_ps2_monitor (
		.clk_sys, .ps2_kbd_clk, .ps2_kbd_data,
		.frame_word(mon_frame), .frame_cnt(mon_cnt), .frame_errs(mon_errs)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function logic [7:0] rand_byte();
		rng_state = lcg_next(rng_state);
		return rng_state[23:16];
	endfunction

	// expected event of one keyboard transfer, bytes in lane order
	function automatic key_event_t key_ref(input logic [31:0] seq, input int n);
		key_event_t ev;
		logic       pressed;
		logic       extended;
		logic [7:0] b;
		ev = '0;
		pressed = 1'b1;
		extended = 1'b0;
		for (int i = 0; i < n; i++) begin
			b = seq[i*8 +: 8];
			if (b == 8'hE0)
				extended = 1'b1;
			else if (b == 8'hF0)
				pressed = 0;
			else
				ev = '{pressed: pressed, extended: extended, code: b};
		end
		return ev;
	endfunction

	// stop 1, odd parity, data lsb first, start 0
	function automatic logic [10:0] ps2_frame(input logic [7:0] b);
		return {1'b1, ~^b, b, 1'b0};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s: got %h expected %h", name, got, exp);
		end
	endtask

	// half an spi period, 4 clk_sys cycles
	task automatic spi_half();
		repeat (4) @(posedge clk_sys);
		#1;
	endtask

	// mosi changes while SPI_CLK is low, miso is read just before the rise
	task automatic spi_byte(input logic [7:0] b, output logic [7:0] r);
		for (int k = 7; k >= 0; k--) begin
			SPI_MOSI = b[k];
			spi_half();
			r[k] = SPI_MISO;
			SPI_CLK = 1'b1;
			spi_half();
			SPI_CLK = 1'b0;
		end
	endtask

	// one framed transfer of tx_q, reply checked per byte
	task automatic run_transfer();
		logic [7:0] reply;
		SPI_SS_IO = 1'b0;
		for (int i = 0; i < tx_q.size(); i++) begin
			spi_byte(tx_q[i], reply);
			check_value($sformatf("SPI_MISO byte %0d", i), reply, (i == 0) ? CORE_ID : 8'h00);
		end
		// last byte has to reach clk_sys before the frame ends
		spi_half();
		SPI_SS_IO = 1'b1;
		repeat (8) @(posedge clk_sys);
		#1;
		tx_q.delete();
	endtask

	task automatic reg_transfer(input cmd_e cmd, input int n, output logic [31:0] value);
		logic [7:0] b;
		value = '0;
		tx_q.push_back(cmd);
		for (int i = 0; i < n; i++) begin
			b = rand_byte();
			// little endian, bytes past the fourth are ignored
			if (i < 4)
				value[i*8 +: 8] = b;
			tx_q.push_back(b);
		end
		run_transfer();
	endtask

	task automatic kbd_transfer(input logic [31:0] seq, input int n);
		ev_q.push_back(key_ref(seq, n));
		tx_q.push_back(CMD_KBD);
		for (int i = 0; i < n; i++) begin
			tx_q.push_back(seq[i*8 +: 8]);
			byte_q.push_back(seq[i*8 +: 8]);
			kbd_total++;
		end
		run_transfer();
	endtask

	// key events compared where key_strobe is stable
	always @(negedge clk_sys) begin
		if (key_strobe) begin
			if (ev_q.size() == 0) begin
				errors++;
				$display("key_strobe pulsed while no key event was expected");
			end else begin
				check_value("key", key, ev_q.pop_front());
			end
		end
	end

	// each finished ps2 frame against the next keyboard byte
	always @(posedge clk_sys) begin
		if (mon_cnt != frames_seen) begin
			frames_seen++;
			if (byte_q.size() == 0) begin
				errors++;
				$display("ps2 frame sent while no keyboard byte was queued");
			end else begin
				check_value("ps2 frame", mon_frame, ps2_frame(byte_q.pop_front()));
			end
		end
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the DUT did not finish", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	initial begin
		logic [31:0] exp;
		SPI_CLK = 1'b0;
		SPI_MOSI = 1'b0;
		SPI_SS_IO = 1'b0;
		#1;
		// rising ss resets the spi side, held for 4 cycles
		SPI_SS_IO = 1'b1;
		repeat (4) @(posedge clk_sys);
		#1;

		reg_transfer(CMD_JOY0, 6, exp);
		check_value("joystick_0", joystick_0, exp);
		reg_transfer(CMD_JOY1, 6, exp);
		check_value("joystick_1", joystick_1, exp);
		reg_transfer(CMD_STATUS, 4, exp);
		check_value("status", status, exp);

		// buttons byte fields
		reg_transfer(CMD_BUT_SW, 1, exp);
		check_value("buttons", buttons, exp[1:0]);
		check_value("switches", switches, exp[3:2]);
		check_value("scandoubler_disable", scandoubler_disable, exp[4]);
		check_value("ypbpr", ypbpr, exp[5]);
		check_value("no_csync", no_csync, exp[6]);

		// make, break, extended make, extended break
		kbd_transfer(32'h0000001C, 1);
		kbd_transfer(32'h00001CF0, 2);
		kbd_transfer(32'h000075E0, 2);
		kbd_transfer(32'h0075F0E0, 3);

		while (frames_seen < kbd_total)
			@(posedge clk_sys);
		repeat (4 * (PS2_DIV + 1)) @(posedge clk_sys);
		check_value("ps2_kbd_clk", ps2_kbd_clk, 1'b1);
		check_value("pending key events", ev_q.size(), 0);
		check_value("pending ps2 bytes", byte_q.size(), 0);

		$display("checks: %0d, errors: %0d, ps2 frame errors: %0d", checks, errors, mon_errs);
		if (errors + mon_errs == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- vlog.f
source/user_io_pkg.sv
source/spi_frame_rx.sv
source/cmd_decoder.sv
source/ps2_fifo.sv
source/ps2_tx.sv
source/user_io.sv
test/tb_ps2_monitor.sv
test/tb_user_io.sv
